/* verif/mem_golden.txt */
# kind rd rs1 rs2 imm memread memwrite memtoreg regwrite imemwrite rx exp_data exp_addr
# kind 0 addi 1 load 2 store 3 uart load 4 uart store 5 imem store, all hex
# addi chain with bypass
0 01 00 00 00000011 0 0 0 1 0 00 00000011 00000000
0 02 01 00 00000022 0 0 0 1 0 00 00000033 00000000
0 03 02 00 00000100 0 0 0 1 0 00 00000133 00000000
# write to r0 shows on wb but r0 still reads zero
0 00 03 00 00000005 0 0 0 1 0 00 00000138 00000000
0 04 00 00 00000007 0 0 0 1 0 00 00000007 00000000
0 05 04 00 fffffff9 0 0 0 1 0 00 00000000 00000000
0 06 00 00 00000040 0 0 0 1 0 00 00000040 00000000
# store miss then load hit
2 00 06 03 00000000 0 1 0 0 0 00 00000133 00000000
1 07 06 00 00000000 1 0 1 1 0 00 00000133 00000000
0 08 07 00 00000001 0 0 0 1 0 00 00000134 00000000
1 09 06 00 00000004 1 0 1 1 0 00 00000000 00000000
2 00 06 08 00000008 0 1 0 0 0 00 00000134 00000000
2 00 06 02 00000008 0 1 0 0 0 00 00000033 00000000
1 0b 06 00 00000008 1 0 1 1 0 00 00000033 00000000
1 0c 06 00 00000000 1 0 1 1 0 00 00000133 00000000
# uart accesses
0 0a 00 00 03fffffc 0 0 0 1 0 00 03fffffc 00000000
3 0d 0a 00 00000000 1 0 1 1 0 a5 000000a5 00000000
0 0e 0d 00 00000100 0 0 0 1 0 00 000001a5 00000000
4 00 0a 03 00000000 0 1 0 0 0 00 00000133 00000000
3 0f 00 00 fffffffc 1 0 1 1 0 5a 0000005a 00000000
4 00 0a 0f 00000000 0 1 0 0 0 00 0000005a 00000000
# imem store, then more cache traffic
5 00 06 08 00000020 0 0 0 0 1 00 00000134 00000060
0 10 0c 00 00000010 0 0 0 1 0 00 00000143 00000000
1 11 06 00 00000008 1 0 1 1 0 00 00000033 00000000
0 12 11 00 000000cd 0 0 0 1 0 00 00000100 00000000

/* sources.f */
verilog/core_pkg.sv
verilog/ex_mem_if.sv
verilog/exec_unit.sv
verilog/memory_stage.sv
verilog/data_cache.sv
verilog/reg_writeback.sv
verilog/mem_subsystem.sv
verif/tb_mem_subsystem.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_mem_subsystem

# the pass line decides the result
out=$(./obj_dir/Vtb_mem_subsystem 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed"

/* verif/tb_mem_subsystem.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_mem_subsystem;

    import core_pkg::*;

    localparam int MISS_CYCLES = 4;
    localparam int DMEM_WORDS  = 256;
    // worst miss or fifo wait is far below this
    localparam int STALL_LIMIT = 40;
    localparam int NUM_FIELDS  = 13;

    // golden line kinds
    localparam int KIND_ALU     = 0;
    localparam int KIND_LOAD    = 1;
    localparam int KIND_STORE   = 2;
    localparam int KIND_UART_LD = 3;
    localparam int KIND_UART_ST = 4;
    localparam int KIND_IMEM_ST = 5;

    // one golden line
    typedef struct packed {
        int    kind;
        inst_t inst;
        byte_t rx;
        word_t exp_data;
        word_t exp_addr;
    } vec_t;

    logic      clk;
    logic      rstn;
    inst_t     inst;
    logic      stall;
    reg_addr_t wb_rd;
    logic      wb_regwrite;
    word_t     wb_data;
    logic      imemwrite;
    word_t     imemwaddr;
    word_t     imemwdata;
    byte_t     uart_rx_data;
    logic      empty;
    logic      full;
    logic      uart_rd_en;
    logic      uart_wr_en;
    byte_t     uart_tx_data;

    vec_t vecs[$];
    int   error_count;

    mem_subsystem #(
        .MISS_CYCLES (MISS_CYCLES),
        .DMEM_WORDS  (DMEM_WORDS)
    ) i_mem_subsystem (
        .clk          (clk),
        .rstn         (rstn),
        .inst         (inst),
        .stall        (stall),
        .wb_rd        (wb_rd),
        .wb_regwrite  (wb_regwrite),
        .wb_data      (wb_data),
        .imemwrite    (imemwrite),
        .imemwaddr    (imemwaddr),
        .imemwdata    (imemwdata),
        .uart_rx_data (uart_rx_data),
        .empty        (empty),
        .full         (full),
        .uart_rd_en   (uart_rd_en),
        .uart_wr_en   (uart_wr_en),
        .uart_tx_data (uart_tx_data)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run();
        error_count++;
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(reg_addr_t got, reg_addr_t exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(byte_t got, byte_t exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // hex columns, lines starting with # skipped
    task automatic load_golden();
        int          fd;
        int          cnt;
        string       text;
        logic [31:0] f_kind, f_rd, f_rs1, f_rs2;
        logic [31:0] f_imm, f_mr, f_mw, f_m2r;
        logic [31:0] f_rw, f_iw, f_rx, f_ed, f_ea;
        vec_t        v;
        fd = $fopen("verif/mem_golden.txt", "r");
        if (fd == 0) begin
            report_error("cannot open verif/mem_golden.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            cnt = $fgets(text, fd);
            if (cnt > 0 && text.len() > 1 && text[0] != "#") begin
                cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f_kind, f_rd, f_rs1, f_rs2, f_imm, f_mr, f_mw,
                              f_m2r, f_rw, f_iw, f_rx, f_ed, f_ea);
                if (cnt != NUM_FIELDS) begin
                    report_error("malformed line in golden file");
                end
                v.kind           = int'(f_kind);
                v.inst.rd        = reg_addr_t'(f_rd);
                v.inst.rs1       = reg_addr_t'(f_rs1);
                v.inst.rs2       = reg_addr_t'(f_rs2);
                v.inst.imm       = f_imm;
                v.inst.memread   = f_mr[0];
                v.inst.memwrite  = f_mw[0];
                v.inst.memtoreg  = f_m2r[0];
                v.inst.regwrite  = f_rw[0];
                v.inst.imemwrite = f_iw[0];
                v.rx             = f_rx[7:0];
                v.exp_data       = f_ed;
                v.exp_addr       = f_ea;
                vecs.push_back(v);
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            report_error("golden file holds no instructions");
        end
    endtask

    // EM outputs in the cycle the instruction commits
    task automatic check_commit(vec_t v, int idx);
        string tag;
        tag = $sformatf("line %0d", idx);
        check_bit(wb_regwrite, v.inst.regwrite, {tag, " wb_regwrite"});
        if (v.inst.regwrite) begin
            check_reg(wb_rd, v.inst.rd, {tag, " wb_rd"});
            check_word(wb_data, v.exp_data, {tag, " wb_data"});
        end
        check_bit(uart_rd_en, v.kind == KIND_UART_LD, {tag, " uart_rd_en"});
        check_bit(uart_wr_en, v.kind == KIND_UART_ST, {tag, " uart_wr_en"});
        // tx carries the low byte of the store data
        if (v.kind == KIND_UART_ST) begin
            check_byte(uart_tx_data, v.exp_data[7:0], {tag, " uart_tx_data"});
        end
        check_bit(imemwrite, v.kind == KIND_IMEM_ST, {tag, " imemwrite"});
        if (v.kind == KIND_IMEM_ST) begin
            check_word(imemwaddr, v.exp_addr, {tag, " imemwaddr"});
            check_word(imemwdata, v.exp_data, {tag, " imemwdata"});
        end
    endtask

    initial begin : main
        int   cur;
        int   em;
        int   stall_cycles;
        int   rx_wait;
        int   tx_wait;
        logic done;
        logic stall_s;
        logic rd_req_s;
        logic wr_req_s;
        logic empty_s;
        logic full_s;

        // fifos start not ready
        rstn         = 1'b0;
        inst         = '0;
        uart_rx_data = '0;
        empty        = 1'b1;
        full         = 1'b1;
        error_count  = 0;
        rx_wait      = 0;
        tx_wait      = 0;
        void'($urandom(32'h3568_4097));
        load_golden();

        // reset for 5 cycles, first instruction goes in on release
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        inst <= vecs[0].inst;

        cur          = 0;
        em           = -1;
        done         = 1'b0;
        stall_cycles = 0;
        while (!done) begin
            // mid-cycle sample, all outputs settled
            @(negedge clk);
            stall_s  = stall;
            rd_req_s = uart_rd_en;
            wr_req_s = uart_wr_en;
            empty_s  = empty;
            full_s   = full;
            if (rd_req_s && empty_s && !stall_s) begin
                report_error("stall low while a uart load waits on an empty rx fifo");
            end
            if (wr_req_s && full_s && !stall_s) begin
                report_error("stall low while a uart store waits on a full tx fifo");
            end
            if (stall_s) begin
                stall_cycles++;
                if (stall_cycles > STALL_LIMIT) begin
                    report_error($sformatf("stall stuck high on line %0d", em));
                end
            end else begin
                stall_cycles = 0;
                if (em >= 0) begin
                    check_commit(vecs[em], em);
                    done = (em == vecs.size() - 1);
                end else begin
                    check_bit(wb_regwrite, 1'b0, "bubble wb_regwrite");
                end
            end

            @(posedge clk);
            // rx fifo model: byte arrives after a random wait
            if (rd_req_s && !stall_s) begin
                empty <= 1'b1;
            end else if (rd_req_s && empty_s) begin
                if (rx_wait == 0) begin
                    rx_wait = 1 + int'($urandom % 4);
                end else begin
                    rx_wait--;
                    if (rx_wait == 0) begin
                        empty <= 1'b0;
                    end
                end
            end
            // tx fifo model: space frees after a random wait
            if (wr_req_s && !stall_s) begin
                full <= 1'b1;
            end else if (wr_req_s && full_s) begin
                if (tx_wait == 0) begin
                    tx_wait = 1 + int'($urandom % 4);
                end else begin
                    tx_wait--;
                    if (tx_wait == 0) begin
                        full <= 1'b0;
                    end
                end
            end
            // pipeline moved, next line into execute
            if (!stall_s) begin
                em = (cur < vecs.size()) ? cur : -1;
                cur++;
                if (cur < vecs.size()) begin
                    inst <= vecs[cur].inst;
                end else begin
                    inst <= '0;
                end
                if (em >= 0) begin
                    uart_rx_data <= vecs[em].rx;
                end else begin
                    uart_rx_data <= '0;
                end
            end
        end

        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mem_subsystem.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int MISS_CYCLES = 4,
    parameter int DMEM_WORDS  = 256
) (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::inst_t     inst,
    output logic                stall,
    output core_pkg::reg_addr_t wb_rd,
    output logic                wb_regwrite,
    output core_pkg::word_t     wb_data,
    output logic                imemwrite,
    output core_pkg::word_t     imemwaddr,
    output core_pkg::word_t     imemwdata,
    input  core_pkg::byte_t     uart_rx_data,
    input  logic                empty,
    input  logic                full,
    output logic                uart_rd_en,
    output logic                uart_wr_en,
    output core_pkg::byte_t     uart_tx_data
);

    import core_pkg::*;

    // register file read path
    reg_addr_t rs1_idx;
    reg_addr_t rs2_idx;
    word_t     rs1_data;
    word_t     rs2_data;

    // pipeline advance level
    logic fin;

    // cache port
    word_t dc_addr;
    word_t dc_wdata;
    word_t dc_rdata;
    logic  dc_we;
    logic  dc_re;
    logic  dc_miss;

    ex_mem_if ex ();

    exec_unit i_exec_unit (
        .inst     (inst),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1_idx),
        .rs2      (rs2_idx),
        .ex       (ex.producer)
    );

    // fin loops back as its own enable
    memory_stage i_memory_stage (
        .clk          (clk),
        .rstn         (rstn),
        .enable       (fin),
        .ex           (ex.consumer),
        .fin          (fin),
        .addr         (dc_addr),
        .wdata        (dc_wdata),
        .rdata        (dc_rdata),
        .write_enable (dc_we),
        .read_enable  (dc_re),
        .miss         (dc_miss),
        .rd           (wb_rd),
        .regwrite     (wb_regwrite),
        .regwdata     (wb_data),
        .imemwrite    (imemwrite),
        .imemwaddr    (imemwaddr),
        .imemwdata    (imemwdata),
        .uart_rx_data (uart_rx_data),
        .empty        (empty),
        .full         (full),
        .uart_rd_en   (uart_rd_en),
        .uart_wr_en   (uart_wr_en),
        .uart_tx_data (uart_tx_data)
    );

    data_cache #(
        .MISS_CYCLES (MISS_CYCLES),
        .DMEM_WORDS  (DMEM_WORDS)
    ) i_data_cache (
        .clk          (clk),
        .rstn         (rstn),
        .addr         (dc_addr),
        .wdata        (dc_wdata),
        .write_enable (dc_we),
        .read_enable  (dc_re),
        .rdata        (dc_rdata),
        .miss         (dc_miss)
    );

    // commits only on cycles where the pipeline moves
    reg_writeback i_reg_writeback (
        .clk      (clk),
        .rstn     (rstn),
        .enable   (fin),
        .rd       (wb_rd),
        .regwrite (wb_regwrite),
        .regwdata (wb_data),
        .rs1      (rs1_idx),
        .rs2      (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign stall = !fin;

endmodule

`default_nettype wire

/* verilog/reg_writeback.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_writeback (
    input  logic                clk,
    input  logic                rstn,
    input  logic                enable,
    input  core_pkg::reg_addr_t rd,
    input  logic                regwrite,
    input  core_pkg::word_t     regwdata,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);

    import core_pkg::*;

    localparam int NUM_REGS = 1 << $bits(reg_addr_t);

    word_t regs [NUM_REGS];

    // commit strobe, r0 never written
    logic wr_en;

    // value pending for rd this cycle
    logic bypass_valid;

    assign wr_en        = regwrite && enable && (rd != '0);
    assign bypass_valid = regwrite && (rd != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= regwdata;
        end
    end

    // read port with write-first bypass
    // bypass ignores enable, execute is held until fin anyway
    function automatic word_t read_port(reg_addr_t idx, word_t stored);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (bypass_valid && (idx == rd)) begin
            val = regwdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1, regs[rs1]);
        rs2_data = read_port(rs2, regs[rs2]);
    end

endmodule

`default_nettype wire

/* verilog/data_cache.sv */
`default_nettype none
`timescale 1ns/1ps

module data_cache #(
    parameter int MISS_CYCLES = 4,
    parameter int DMEM_WORDS  = 256
) (
    input  logic            clk,
    input  logic            rstn,
    input  core_pkg::word_t addr,
    input  core_pkg::word_t wdata,
    input  logic            write_enable,
    input  logic            read_enable,
    output core_pkg::word_t rdata,
    output logic            miss
);

    import core_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);
    localparam int CNT_W = $clog2(MISS_CYCLES + 1);

    // backing store
    word_t mem [DMEM_WORDS];

    // the single line
    word_t       line;
    logic [29:0] line_tag;
    logic        line_valid;

    // word address waiting for its fill
    logic [29:0] fill_tag;

    cache_state_t     state;
    logic [CNT_W-1:0] fill_cnt;

    logic             access;
    logic             hit;
    logic             fill_done;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] fill_idx;

    // array starts out zeroed
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign access    = read_enable || write_enable;
    assign idx       = addr[IDX_W+1:2];
    assign fill_idx  = fill_tag[IDX_W-1:0];
    // tag is the full word address
    assign hit       = line_valid && (line_tag == addr[31:2]);
    assign fill_done = (state == FILL) && (fill_cnt == '0);

    // controller
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            fill_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (access && !hit) begin
                        state      <= FILL;
                        fill_cnt   <= CNT_W'(MISS_CYCLES - 1);
                        line_valid <= 1'b0;
                    end
                end
                FILL: begin
                    if (fill_cnt == '0) begin
                        state      <= IDLE;
                        line_valid <= 1'b1;
                    end else begin
                        fill_cnt <= fill_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // line contents and pending tag
    always_ff @(posedge clk) begin
        if (state == IDLE && access) begin
            // store hit refreshes the line
            if (hit && write_enable) begin
                line <= wdata;
            end
            if (!hit) begin
                fill_tag <= addr[31:2];
            end
        end
        // array already holds any write-through data
        if (fill_done) begin
            line     <= mem[fill_idx];
            line_tag <= fill_tag;
        end
    end

    // write-through, hit or miss
    always_ff @(posedge clk) begin
        if (state == IDLE && write_enable) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = line;
    assign miss  = (state == FILL);

    // miss lasts exactly the fill time
    a_miss_len: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(miss) |-> ##MISS_CYCLES !miss
    ) else $error("data_cache: miss held longer than MISS_CYCLES");

endmodule

`default_nettype wire

/* verilog/memory_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module memory_stage (
    input  logic                clk,
    input  logic                rstn,
    input  logic                enable,
    ex_mem_if.consumer          ex,
    output logic                fin,
    output core_pkg::word_t     addr,
    output core_pkg::word_t     wdata,
    input  core_pkg::word_t     rdata,
    output logic                write_enable,
    output logic                read_enable,
    input  logic                miss,
    output core_pkg::reg_addr_t rd,
    output logic                regwrite,
    output core_pkg::word_t     regwdata,
    output logic                imemwrite,
    output core_pkg::word_t     imemwaddr,
    output core_pkg::word_t     imemwdata,
    input  core_pkg::byte_t     uart_rx_data,
    input  logic                empty,
    input  logic                full,
    output logic                uart_rd_en,
    output logic                uart_wr_en,
    output core_pkg::byte_t     uart_tx_data
);

    import core_pkg::*;

    // EM pipeline register
    inst_t inst_em;
    word_t aluresult_em;
    word_t result_em;
    word_t rdata1_em;

    // uart address hits on the execute and EM side
    logic is_uart_ex;
    logic is_uart_em;

    // load data before the write-back select
    word_t memrdata;

    // capture only while the pipeline advances
    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst_em      <= '0;
            aluresult_em <= '0;
            result_em    <= '0;
            rdata1_em    <= '0;
        end else if (enable) begin
            inst_em      <= ex.inst;
            aluresult_em <= ex.aluresult;
            result_em    <= ex.result;
            rdata1_em    <= ex.rdata1;
        end
    end

    assign is_uart_ex = (ex.aluresult[25:0] == UART_ADDR);
    assign is_uart_em = (aluresult_em[25:0] == UART_ADDR);

    // cache access issues from execute so data is back in the EM cycle
    // during a miss the cache sees the held EM access
    assign addr  = miss ? aluresult_em : ex.aluresult;
    assign wdata = miss ? rdata1_em : ex.rdata1;

    // no new access while stalled so cache and EM stay aligned
    assign write_enable = !miss && enable && ex.inst.memwrite && !is_uart_ex;
    assign read_enable  = !miss && enable && ex.inst.memread && !is_uart_ex;

    // uart side works off the EM register
    assign uart_rd_en   = inst_em.memread && is_uart_em;
    assign uart_wr_en   = inst_em.memwrite && is_uart_em;
    assign uart_tx_data = rdata1_em[7:0];

    // rx byte zero-extended
    assign memrdata = is_uart_em ? {24'b0, uart_rx_data} : rdata;

    // write-back select
    assign regwdata = inst_em.memtoreg ? memrdata : result_em;
    assign rd       = inst_em.rd;
    assign regwrite = inst_em.regwrite;

    // imem store goes out untouched
    assign imemwrite = inst_em.imemwrite;
    assign imemwaddr = aluresult_em;
    assign imemwdata = rdata1_em;

    // done unless waiting on the cache or a fifo
    assign fin = !(uart_rd_en && empty) && !(uart_wr_en && full) && !miss;

    // a miss always belongs to the cache access held in EM
    // never to a uart access
    a_miss_not_uart: assert property (
        @(posedge clk) disable iff (!rstn)
        miss |-> !(uart_rd_en || uart_wr_en)
    ) else $error("memory_stage: cache miss while EM holds a uart access");

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_unit (
    input  core_pkg::inst_t   inst,
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    ex_mem_if.producer        ex
);

    import core_pkg::*;

    // base + offset
    word_t sum;

    // register file read indices
    // data comes back combinationally, bypassed if needed
    assign rs1 = inst.rs1;
    assign rs2 = inst.rs2;

    // single adder serves both addi and load/store addressing
    assign sum = rs1_data + inst.imm;

    // instruction travels on unchanged
    assign ex.inst = inst;

    // address for memory ops
    assign ex.aluresult = sum;

    // addi result, same adder output
    assign ex.result = sum;

    // store data from the second operand
    assign ex.rdata1 = rs2_data;

    // decoder must never emit a load and a store at once
    // the memory stage steering assumes one or the other
    always_comb begin
        assert (!(inst.memread && inst.memwrite))
            else $error("exec_unit: memread and memwrite both set");
    end

endmodule

`default_nettype wire

/* verilog/ex_mem_if.sv */
`default_nettype none
`timescale 1ns/1ps

// execute results handed to the memory stage
interface ex_mem_if;

    import core_pkg::*;

    // instruction currently in execute
    inst_t inst;

    // rs1 + imm, used as load/store address
    word_t aluresult;

    // value written back for non-memory instructions
    word_t result;

    // rs2 value, store data
    word_t rdata1;

    // execute side drives everything
    modport producer (
        output inst,
        output aluresult,
        output result,
        output rdata1
    );

    // memory stage samples into its EM register
    modport consumer (
        input inst,
        input aluresult,
        input result,
        input rdata1
    );

endinterface

`default_nettype wire

/* verilog/core_pkg.sv */
package core_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // register index, 64 architectural registers
    typedef logic [5:0] reg_addr_t;

    // one uart fifo entry
    typedef logic [7:0] byte_t;

    // decoded instruction bundle
    // only the fields the back end looks at
    typedef struct packed {
        // destination and source registers
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        // sign-extended immediate, added to rs1
        word_t     imm;
        // load from dmem or uart
        logic      memread;
        // store to dmem or uart
        logic      memwrite;
        // write-back takes memory data, not alu result
        logic      memtoreg;
        // write-back enable
        logic      regwrite;
        // store into instruction memory
        logic      imemwrite;
    } inst_t;

    // memory-mapped uart word
    // compared against address bits 25:0 only
    localparam logic [25:0] UART_ADDR = 26'h3fffffc;

    // data cache controller states
    // IDLE accepts accesses, FILL waits out the miss
    typedef enum logic {
        IDLE,
        FILL
    } cache_state_t;

endpackage
